/* all.f */
+incdir+.
stream_pkg.sv
if_axi_stream.sv
axi_stream_fifo.sv
beat_counter.sv
frame_fsm.sv
stream_check_top.sv
stream_check_asserts.sv
stream_check_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the stream checker testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module stream_check_tb -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo ">>> FAIL" >> sim.log
grep -q ">>> PASS" sim.log || echo ">>> FAIL" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
exit 0

/* stream_check_tb.sv */
// --------------------
// Random-stimulus testbench for the stream checker, seeded for repeatable runs
// Inputs and output ready signals change on the falling clock edge
// A queue model applies the framing rules to every beat the DUT accepts
// --------------------
`include "stream_defs.svh"

module stream_check_tb import stream_pkg::*; ();

  // One output beat with its flags, in the same order as the output ports
  typedef struct packed {
    logic  sop;
    logic  eop;
    logic  err;
    beat_t b;
  } flit_t;

  logic                 i_clk, i_rst;
  logic                 i_val, i_sop, i_eop, i_err;
  logic [`DAT_BITS-1:0] i_dat;
  logic [`CTL_BITS-1:0] i_ctl;
  logic [`MOD_BITS-1:0] i_mod;
  logic                 i_rdy, i_stat_rdy;
  logic                 o_rdy, o_val, o_sop, o_eop, o_err;
  logic [`DAT_BITS-1:0] o_dat;
  logic [`CTL_BITS-1:0] o_ctl;
  logic [`MOD_BITS-1:0] o_mod;
  logic                 o_stat_val, o_stat_oversize, o_stat_framing, o_stat_err;
  logic [`LEN_BITS-1:0] o_stat_len;

  int    errors = 0;
  int    checks = 0;
  bit    random_bp = 1'b0;   // Random output back-pressure on
  bit    gaps = 1'b0;        // Random idle cycles between input beats
  bit    stall_seen = 1'b0;  // o_rdy was seen low with a beat waiting
  time   stall_end = 0;      // Outputs held off until this time
  flit_t exp_q[$];           // Expected beats in order
  stat_t stat_q[$];          // Expected status records in order
  bit    m_in_pkt = 1'b0;    // Model framer state
  int    m_count = 0;
  logic  m_framing = 1'b0;
  logic  m_in_err = 1'b0;

  stream_check_top dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_beat(input flit_t exp, input flit_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      if ({got.sop, got.eop, got.err} !== {exp.sop, exp.eop, exp.err}) begin
        $display("error: o_sop,o_eop,o_err expected %h got %h",
                 {exp.sop, exp.eop, exp.err}, {got.sop, got.eop, got.err});
      end
      if (got.b.dat !== exp.b.dat) begin
        $display("error: o_dat expected %h got %h", exp.b.dat, got.b.dat);
      end
      if ({got.b.ctl, got.b.mod} !== {exp.b.ctl, exp.b.mod}) begin
        $display("error: o_ctl,o_mod expected %h got %h", {exp.b.ctl, exp.b.mod},
                 {got.b.ctl, got.b.mod});
      end
    end
  endtask

  task automatic check_stat(input stat_t exp, input stat_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: o_stat_len,o_stat_oversize,o_stat_framing,o_stat_err expected %h got %h",
               exp, got);
    end
  endtask

  // Framing rules applied to one accepted input beat
  task automatic model_accept(input logic sop, eop, err, input beat_t b);
    bit    past;
    flit_t f;
    stat_t s;
    if (!m_in_pkt && !sop) begin
      return;  // Orphan beat, dropped
    end
    if (!m_in_pkt) begin
      m_count   = 0;
      m_framing = 1'b0;
      m_in_err  = 1'b0;
    end
    past      = m_in_pkt && (m_count >= `MAX_BEATS);  // Beat MAX_BEATS+1 or later
    m_framing = m_framing || (m_in_pkt && sop);
    m_in_err  = m_in_err || err;
    if (m_count < (1 << `LEN_BITS) - 1) begin
      m_count++;  // Saturating length
    end
    f.sop = !m_in_pkt;
    f.eop = eop;
    f.err = eop && (past || m_framing || m_in_err);
    f.b   = b;
    if (eop || !past) begin
      exp_q.push_back(f);
    end
    if (eop) begin
      s.len      = `LEN_BITS'(m_count);
      s.oversize = past;
      s.framing  = m_framing;
      s.in_err   = m_in_err;
      stat_q.push_back(s);
    end
    m_in_pkt = !eop;
  endtask

  // Entered on a falling edge, returns on a falling edge with i_val low
  task automatic send_beat(input logic sop, eop, err);
    beat_t b;
    int    waited;
    b.dat = `DAT_BITS'($urandom);
    b.ctl = `CTL_BITS'($urandom);
    b.mod = `MOD_BITS'($urandom);
    {i_sop, i_eop, i_err} = {sop, eop, err};
    {i_dat, i_ctl, i_mod} = b;
    i_val  = 1'b1;
    waited = 0;
    while (!o_rdy) begin  // o_rdy is registered, so stable here
      stall_seen = 1'b1;
      @(negedge i_clk);
      waited++;
      if (waited > 400) begin
        abort_run("an input beat was never accepted");
      end
    end
    model_accept(sop, eop, err, b);  // Taken at the coming rising edge
    @(negedge i_clk);
    i_val = 1'b0;
    if (gaps && $urandom_range(3) == 0) begin
      @(negedge i_clk);
    end
  endtask

  // stray and err_at are beat indices, -1 for none
  task automatic send_packet(input int len, input int stray, input int err_at);
    for (int i = 0; i < len; i++) begin
      send_beat(i == 0 || i == stray, i == len - 1, i == err_at);
    end
  endtask

  task automatic random_packet();
    int len;
    int stray;
    int err_at;
    len    = $urandom_range(1, 10);
    stray  = ($urandom_range(7) == 0) ? int'($urandom_range(1, 9)) : -1;
    err_at = ($urandom_range(7) == 0) ? int'($urandom_range(0, 9)) : -1;
    if ($urandom_range(5) == 0) begin
      send_beat(1'b0, 1'b0, 1'b0);  // Orphan between packets
    end
    send_packet(len, stray, err_at);
  endtask

  // Output side sink, checks each beat and record as it is taken
  task automatic serve_outputs();
    flit_t got;
    stat_t sgot;
    forever begin
      @(negedge i_clk);
      if ($time < stall_end) begin
        i_rdy      = 1'b0;
        i_stat_rdy = 1'b0;
      end else if (random_bp) begin
        i_rdy      = ($urandom_range(3) != 0);
        i_stat_rdy = ($urandom_range(2) != 0);
      end else begin
        i_rdy      = 1'b1;
        i_stat_rdy = 1'b1;
      end
      if (!i_rst && o_val && i_rdy) begin
        got = {o_sop, o_eop, o_err, o_dat, o_ctl, o_mod};
        if (exp_q.size() == 0) begin
          errors++;
          $display("an output beat appeared when none was expected");
        end else begin
          check_beat(exp_q.pop_front(), got);
        end
      end
      if (!i_rst && o_stat_val && i_stat_rdy) begin
        sgot = {o_stat_len, o_stat_oversize, o_stat_framing, o_stat_err};
        if (stat_q.size() == 0) begin
          errors++;
          $display("a status record appeared when none was expected");
        end else begin
          check_stat(stat_q.pop_front(), sgot);
        end
      end
    end
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || stat_q.size() != 0) begin
      @(negedge i_clk);
      waited++;
      if (waited > 2000) begin
        abort_run("expected output never arrived");
      end
    end
    @(negedge i_clk);
    check_flag("o_val", o_val, 1'b0);  // Nothing left over or duplicated
    check_flag("o_stat_val", o_stat_val, 1'b0);
  endtask

  task automatic report_test(input int num, input string name, input int base);
    if (errors == base) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - base);
    end
  endtask

  initial begin
    int base;
    void'($urandom(32'h8e0e));
    i_rst = 1'b1;
    {i_val, i_sop, i_eop, i_err} = '0;
    {i_dat, i_ctl, i_mod} = '0;
    i_rdy      = 1'b1;
    i_stat_rdy = 1'b1;
    fork
      serve_outputs();
    join_none
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    base  = errors;
    check_flag("o_rdy", o_rdy, 1'b1);
    repeat (3) begin  // Outputs stay quiet for three cycles
      check_flag("o_val", o_val, 1'b0);
      check_flag("o_stat_val", o_stat_val, 1'b0);
      @(negedge i_clk);
    end
    report_test(1, "reset state", base);
    base = errors;
    for (int n = 0; n < 20; n++) begin
      send_packet($urandom_range(1, `MAX_BEATS), -1, -1);
    end
    drain_outputs();
    report_test(2, "clean packets", base);
    base = errors;
    gaps = 1'b1;
    repeat (5) begin
      send_beat(1'b0, 1'($urandom_range(1)), 1'($urandom_range(1)));
    end
    send_packet(3, -1, -1);
    send_beat(1'b0, 1'b1, 1'b0);  // Orphans after a closed packet
    send_beat(1'b0, 1'b0, 1'b1);
    send_packet(1, -1, -1);
    drain_outputs();
    report_test(3, "orphan beats", base);
    base = errors;
    send_packet(`MAX_BEATS + 1, -1, -1);
    send_packet(9, -1, -1);
    send_packet(16, -1, -1);  // Length field saturates from here
    send_packet(20, -1, -1);
    drain_outputs();
    report_test(4, "oversize packets", base);
    base = errors;
    send_packet(5, 2, -1);
    send_packet(4, -1, 1);
    send_packet(3, 1, 2);
    send_packet(1, -1, 0);
    send_packet(6, -1, 5);  // err on the closing beat
    drain_outputs();
    report_test(5, "framing and input errors", base);
    base       = errors;
    random_bp  = 1'b1;
    stall_seen = 1'b0;
    stall_end  = $time + 100 * 20;
    repeat (80) begin
      random_packet();
    end
    drain_outputs();
    if (!stall_seen) begin
      errors++;
      $display("o_rdy never went low while the outputs were stalled");
    end
    report_test(6, "back-pressure", base);
    $display("tests 6 checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* stream_check_asserts.sv */
// --------------------
// Concurrent checks bound into stream_check_top
// Stall checks assume the outputs follow the valid/ready hold rule
// --------------------
`include "stream_defs.svh"

module stream_check_asserts (
  input logic                 i_clk,
  input logic                 i_rst,
  input logic                 i_rdy,
  input logic                 i_stat_rdy,
  input logic                 o_val,
  input logic                 o_sop,
  input logic                 o_eop,
  input logic                 o_err,
  input logic [`DAT_BITS-1:0] o_dat,
  input logic [`CTL_BITS-1:0] o_ctl,
  input logic [`MOD_BITS-1:0] o_mod,
  input logic                 o_stat_val,
  input logic [`LEN_BITS-1:0] o_stat_len,
  input logic                 o_stat_oversize,
  input logic                 o_stat_framing,
  input logic                 o_stat_err,
  input logic                 in_full,
  input logic                 in_emp,
  input logic                 out_full,
  input logic                 out_emp,
  input logic                 stat_full,
  input logic                 stat_emp
);

  // A stalled beat keeps its valid and payload until taken
  beat_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val && !i_rdy |=> o_val && $stable({o_sop, o_eop, o_err, o_dat, o_ctl, o_mod}))
    else $error("output beat changed while stalled");

  stat_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_stat_val && !i_stat_rdy |=> o_stat_val &&
      $stable({o_stat_len, o_stat_oversize, o_stat_framing, o_stat_err}))
    else $error("status record changed while stalled");

  // First three edges after reset release
  quiet_after_reset: assert property (@(posedge i_clk)
    !i_rst && ($past(i_rst, 1) || $past(i_rst, 2) || $past(i_rst, 3))
      |-> !o_val && !o_stat_val)
    else $error("output valid too soon after reset");

  in_flags: assert property (@(posedge i_clk) disable iff (i_rst) !(in_full && in_emp))
    else $error("input FIFO full and empty together");

  out_flags: assert property (@(posedge i_clk) disable iff (i_rst) !(out_full && out_emp))
    else $error("output FIFO full and empty together");

  stat_flags: assert property (@(posedge i_clk) disable iff (i_rst) !(stat_full && stat_emp))
    else $error("status FIFO full and empty together");

endmodule

bind stream_check_top stream_check_asserts u_asserts (
  .i_clk(i_clk), .i_rst(i_rst), .i_rdy(i_rdy), .i_stat_rdy(i_stat_rdy),
  .o_val(o_val), .o_sop(o_sop), .o_eop(o_eop), .o_err(o_err),
  .o_dat(o_dat), .o_ctl(o_ctl), .o_mod(o_mod),
  .o_stat_val(o_stat_val), .o_stat_len(o_stat_len), .o_stat_oversize(o_stat_oversize),
  .o_stat_framing(o_stat_framing), .o_stat_err(o_stat_err),
  .in_full(in_full), .in_emp(in_emp), .out_full(out_full), .out_emp(out_emp),
  .stat_full(stat_full), .stat_emp(stat_emp)
);

/* stream_check_top.sv */
// --------------------
// Packet stream checker, input FIFO to framer to output and status FIFOs
// Two cycles from input to o_val with all FIFOs empty
// o_rdy falls when the input FIFO fills under output back-pressure
// --------------------
`include "stream_defs.svh"

module stream_check_top import stream_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_val,
  input  logic                 i_sop,
  input  logic                 i_eop,
  input  logic                 i_err,
  input  logic [`DAT_BITS-1:0] i_dat,
  input  logic [`CTL_BITS-1:0] i_ctl,
  input  logic [`MOD_BITS-1:0] i_mod,
  input  logic                 i_rdy,       // Beat output ready
  input  logic                 i_stat_rdy,  // Status output ready
  output logic                 o_rdy,
  output logic                 o_val,
  output logic                 o_sop,
  output logic                 o_eop,
  output logic                 o_err,
  output logic [`DAT_BITS-1:0] o_dat,
  output logic [`CTL_BITS-1:0] o_ctl,
  output logic [`MOD_BITS-1:0] o_mod,
  output logic                 o_stat_val,
  output logic [`LEN_BITS-1:0] o_stat_len,
  output logic                 o_stat_oversize,
  output logic                 o_stat_framing,
  output logic                 o_stat_err
);

  if_axi_stream #(.T(beat_t)) in_s ();        // Ports into the input FIFO
  if_axi_stream #(.T(beat_t)) fifo_s ();      // Input FIFO to framer
  if_axi_stream #(.T(beat_t)) beat_s ();      // Framer to output FIFO
  if_axi_stream #(.T(beat_t)) out_s ();       // Output FIFO to ports
  if_axi_stream #(.T(stat_t)) stat_s ();      // Framer to status FIFO
  if_axi_stream #(.T(stat_t)) stat_out_s ();  // Status FIFO to ports

  logic                 in_full, in_emp;      // FIFO flags, watched by the assertions
  logic                 out_full, out_emp;
  logic                 stat_full, stat_emp;
  logic                 cnt_clr, cnt_inc;
  logic [`LEN_BITS-1:0] count;
  logic                 over;

  assign in_s.val  = i_val;
  assign in_s.sop  = i_sop;
  assign in_s.eop  = i_eop;
  assign in_s.err  = i_err;
  assign in_s.data = '{dat: i_dat, ctl: i_ctl, mod: i_mod};
  assign o_rdy     = in_s.rdy;

  assign o_val     = out_s.val;
  assign o_sop     = out_s.sop;
  assign o_eop     = out_s.eop;
  assign o_err     = out_s.err;
  assign o_dat     = out_s.data.dat;
  assign o_ctl     = out_s.data.ctl;
  assign o_mod     = out_s.data.mod;
  assign out_s.rdy = i_rdy;

  assign o_stat_val      = stat_out_s.val;
  assign o_stat_len      = stat_out_s.data.len;
  assign o_stat_oversize = stat_out_s.data.oversize;
  assign o_stat_framing  = stat_out_s.data.framing;
  assign o_stat_err      = stat_out_s.data.in_err;
  assign stat_out_s.rdy  = i_stat_rdy;

  axi_stream_fifo #(.SIZE(`IN_DEPTH), .T(beat_t)) u_in_fifo (
    .i_clk(i_clk), .i_rst(i_rst), .i_axi(in_s), .o_axi(fifo_s),
    .o_full(in_full), .o_emp(in_emp)
  );

  frame_fsm u_frame (
    .i_clk(i_clk), .i_rst(i_rst), .i_in(fifo_s), .o_beat(beat_s), .o_stat(stat_s),
    .o_cnt_clr(cnt_clr), .o_cnt_inc(cnt_inc), .i_count(count), .i_over(over)
  );

  beat_counter u_count (
    .i_clk(i_clk), .i_rst(i_rst), .i_clr(cnt_clr), .i_inc(cnt_inc),
    .o_count(count), .o_over(over)
  );

  axi_stream_fifo #(.SIZE(`OUT_DEPTH), .T(beat_t)) u_out_fifo (
    .i_clk(i_clk), .i_rst(i_rst), .i_axi(beat_s), .o_axi(out_s),
    .o_full(out_full), .o_emp(out_emp)
  );

  axi_stream_fifo #(.SIZE(`STAT_DEPTH), .T(stat_t)) u_stat_fifo (
    .i_clk(i_clk), .i_rst(i_rst), .i_axi(stat_s), .o_axi(stat_out_s),
    .o_full(stat_full), .o_emp(stat_emp)
  );

endmodule

/* frame_fsm.sv */
// --------------------
// Packet framer between the input FIFO and the output and status FIFOs
// Beat path is combinational, a beat is taken only when both sinks show rdy
// Output err is only ever set on the closing beat
// --------------------
`include "stream_defs.svh"

module frame_fsm import stream_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_rst,
  if_axi_stream.sink           i_in,
  if_axi_stream.source         o_beat,
  if_axi_stream.source         o_stat,
  output logic                 o_cnt_clr,  // Restart the beat count
  output logic                 o_cnt_inc,  // Count this beat
  input  logic [`LEN_BITS-1:0] i_count,    // Beats received before this one
  input  logic                 i_over      // i_count is past MAX_BEATS
);

  localparam logic [`LEN_BITS-1:0] MAX_CNT = `LEN_BITS'(`MAX_BEATS);

  frame_state_e state_q;
  logic         framing_q;  // Sticky, a stray sop was seen in this packet
  logic         in_err_q;   // Sticky, an input err was seen in this packet

  logic  in_pkt;
  logic  start;
  logic  past_max;
  logic  last;
  logic  fwd;
  logic  framing;
  logic  in_err;
  logic  bad;
  logic  fire;
  stat_t stat;

  always_comb begin
    in_pkt   = (state_q == IN_PKT);
    start    = !in_pkt && i_in.sop;                              // Opens a packet
    past_max = in_pkt && (i_over || (i_count == MAX_CNT));       // Beat MAX_BEATS+1 or later
    last     = (in_pkt || start) && i_in.eop;                    // Closing beat of a kept packet
    fwd      = start || (in_pkt && (i_in.eop || !past_max));     // Orphans and surplus dropped
    framing  = in_pkt && (framing_q || i_in.sop);                // Includes the current beat
    in_err   = (in_pkt && in_err_q) || i_in.err;
    bad      = past_max || framing || in_err;                    // past_max on eop means oversize
  end

  // Both sinks must have room even for a beat that only goes to one of them
  assign i_in.rdy = o_beat.rdy && o_stat.rdy;
  assign fire     = i_in.val && i_in.rdy;

  // Orphan beats in IDLE are consumed without counting
  assign o_cnt_inc = fire && (in_pkt || i_in.sop);
  assign o_cnt_clr = fire && start;

  // Beat output, sop survives only on the opening beat
  assign o_beat.val  = i_in.val && fwd && o_stat.rdy;
  assign o_beat.sop  = start;
  assign o_beat.eop  = i_in.eop;
  assign o_beat.err  = last && bad;
  assign o_beat.data = i_in.data;

  always_comb begin
    if (start) begin
      stat.len = `LEN_BITS'(1);  // Single-beat packet
    end else if (&i_count) begin
      stat.len = i_count;        // Saturated
    end else begin
      stat.len = i_count + 1'b1;
    end
    stat.oversize = past_max;
    stat.framing  = framing;
    stat.in_err   = in_err;
  end

  // Status record goes out together with the closing beat
  assign o_stat.val  = i_in.val && last && o_beat.rdy;
  assign o_stat.sop  = 1'b1;  // Each record is a packet of its own
  assign o_stat.eop  = 1'b1;
  assign o_stat.err  = bad;
  assign o_stat.data = stat;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q   <= IDLE;
      framing_q <= 1'b0;
      in_err_q  <= 1'b0;
    end else if (fire && (in_pkt || start)) begin
      framing_q <= framing;  // On a start these load the fresh packet's values
      in_err_q  <= in_err;
      if (i_in.eop) begin
        state_q <= IDLE;
      end else begin
        state_q <= IN_PKT;
      end
    end
  end

endmodule

/* beat_counter.sv */
// --------------------
// Per-packet beat counter, saturating at all ones
// o_over is combinational from the registered count
// --------------------
`include "stream_defs.svh"

module beat_counter (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_clr,    // Start of a new packet
  input  logic                 i_inc,    // One more beat received
  output logic [`LEN_BITS-1:0] o_count,  // Beats received so far
  output logic                 o_over    // Count is past MAX_BEATS
);

  localparam logic [`LEN_BITS-1:0] MAX_CNT = `LEN_BITS'(`MAX_BEATS);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_count <= '0;
    end else if (i_clr) begin
      // The sop beat itself counts when it arrives with the clear
      o_count <= {{(`LEN_BITS-1){1'b0}}, i_inc};
    end else if (i_inc && !(&o_count)) begin
      o_count <= o_count + 1'b1;  // Holds at all ones
    end
  end

  assign o_over = (o_count > MAX_CNT);  // Stays high once saturated

endmodule

/* axi_stream_fifo.sv */
// --------------------
// Register-array stream FIFO for any packed payload type
// SIZE must be a power of two and at least 2 so the pointers wrap on their own
// One cycle from write to o_axi.val when empty
// i_axi.rdy stays low while full
// --------------------
module axi_stream_fifo #(
  parameter int  SIZE = 8,
  parameter type T    = logic [7:0]
) (
  input  logic         i_clk,
  input  logic         i_rst,
  if_axi_stream.sink   i_axi,
  if_axi_stream.source o_axi,
  output logic         o_full,
  output logic         o_emp
);

  localparam int A_BITS = $clog2(SIZE);  // Pointer width
  localparam int W      = $bits(T) + 3;  // Payload plus err, eop and sop

  logic [W-1:0]      ram [SIZE];  // Flags and payload per slot
  logic [A_BITS-1:0] rd_ptr;      // Next word to present
  logic [A_BITS-1:0] wr_ptr;      // Next free slot
  logic [A_BITS-1:0] rd_nxt;
  logic [A_BITS-1:0] wr_nxt;
  logic [W-1:0]      rd_word;
  logic              wr_en;
  logic              rd_en;

  assign i_axi.rdy = ~o_full;  // Full FIFO pushes back on the source
  assign o_axi.val = ~o_emp;   // Val comes from a registered flag and never depends on rdy

  assign wr_en = i_axi.val & i_axi.rdy;  // Accepted input beat
  assign rd_en = o_axi.val & o_axi.rdy;  // Beat taken by the sink

  assign wr_nxt = wr_ptr + 1'b1;  // Wraps at SIZE since SIZE is a power of two
  assign rd_nxt = rd_ptr + 1'b1;

  // Head word split back into flags and payload
  assign rd_word    = ram[rd_ptr];
  assign o_axi.err  = rd_word[W-1];
  assign o_axi.eop  = rd_word[W-2];
  assign o_axi.sop  = rd_word[W-3];
  assign o_axi.data = T'(rd_word[W-4:0]);

  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      ram[wr_ptr] <= {i_axi.err, i_axi.eop, i_axi.sop, i_axi.data};  // Flags on top
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      o_emp  <= 1'b1;  // Starts empty
      o_full <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_nxt;
      end
      if (rd_en) begin
        rd_ptr <= rd_nxt;
      end
      // Flags only move when the fill level changes
      if (wr_en && !rd_en) begin
        o_emp <= 1'b0;
        if (wr_nxt == rd_ptr) begin
          o_full <= 1'b1;  // Writer caught up with the reader
        end
      end else if (rd_en && !wr_en) begin
        o_full <= 1'b0;
        if (rd_nxt == wr_ptr) begin
          o_emp <= 1'b1;  // Last word just left
        end
      end
    end
  end

endmodule

/* if_axi_stream.sv */
// --------------------
// Valid/ready stream with flags and a typed payload
// Transfer on a rising edge with val and rdy both high
// Source holds everything stable while val is high and rdy is low
// --------------------
interface if_axi_stream #(
  parameter type T = logic [7:0]
);

  logic val;   // Beat present
  logic rdy;   // Sink can take it
  logic sop;   // First beat of a packet
  logic eop;   // Last beat of a packet
  logic err;   // Error marker
  T     data;  // Payload

  // Source drives all but rdy
  modport source (output val, sop, eop, err, data, input rdy);

  // Sink drives rdy only
  modport sink (input val, sop, eop, err, data, output rdy);

endinterface

/* stream_pkg.sv */
// --------------------
// Payload and state types shared by the stream checker
// Beat flags (sop, eop, err) travel beside the payload and are not part of it
// --------------------
`include "stream_defs.svh"

package stream_pkg;

  // Payload of one beat
  typedef struct packed {
    logic [`DAT_BITS-1:0] dat;  // Data word
    logic [`CTL_BITS-1:0] ctl;  // Sideband control, passed through untouched
    logic [`MOD_BITS-1:0] mod;  // Valid bytes in the last word, zero means all
  } beat_t;

  // One status record per packet, written with its closing beat
  typedef struct packed {
    logic [`LEN_BITS-1:0] len;  // Beats received, saturating at all ones
    logic oversize;             // More than MAX_BEATS beats arrived
    logic framing;              // A start flag showed up inside the packet
    logic in_err;               // Some input beat of the packet carried err
  } stat_t;

  // Framer state
  typedef enum logic {
    IDLE,    // Waiting for a start of packet
    IN_PKT   // Between sop and eop
  } frame_state_e;

endpackage

/* stream_defs.svh */
// --------------------
// Widths, FIFO depths and the packet length limit for the stream checker
// FIFO depths must be powers of two and at least 2
// MAX_BEATS must stay below 2**LEN_BITS - 1 so the length field can count past it
// --------------------
`ifndef STREAM_DEFS_SVH
`define STREAM_DEFS_SVH

`define DAT_BITS   32  // Beat data width
`define CTL_BITS   4   // Sideband control width
`define MOD_BITS   2   // Byte modulus of the last data word

`define IN_DEPTH   8   // Input beat FIFO
`define OUT_DEPTH  8   // Output beat FIFO
`define STAT_DEPTH 4   // One entry per packet

`define MAX_BEATS  6   // Beats forwarded per packet before trimming
`define LEN_BITS   4   // Received length saturates at all ones

`endif
